// File: flist.f
+incdir+common
common/ecc_pkg.sv
hamming/hamming_encoder.sv
hamming/hamming_decoder.sv
design/apb_regs.sv
design/ecc_memory.sv
design/ecc_mem_top.sv
sim/ecc_mem_checker.sv
sim/ecc_mem_tb.sv

// File: Makefile
TOP := ecc_mem_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module $(TOP) --Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "Test failed"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || (echo "Run ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: sim/ecc_mem_tb.sv
////////////////////////////////////////
// Top testbench for the ECC memory,
// drives APB sequences, checker compares
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ecc_settings.svh"

module ecc_mem_tb;

  localparam int CW         = `ECC_CODE_WIDTH;
  localparam int CLK_PERIOD = 8;
  // Reset read 1, clean pass 33, single-bit sweep 105, one-shot 6,
  // count clear 5, unmapped 7, double error 5
  localparam int NUM_OPS     = 162;
  localparam int WATCHDOG_NS = NUM_OPS * 4 * CLK_PERIOD + 1000;

  logic        clk = 1'b0;
  logic        rst;
  logic [7:0]  paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  int          errors;
  int          checks;
  int          bus_errors;
  integer      seed;

  always #(CLK_PERIOD / 2) clk = ~clk;

  ecc_mem_top uut (
    .clk     (clk),
    .rst     (rst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  ecc_mem_checker u_checker (
    .clk     (clk),
    .rst     (rst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .errors  (errors),
    .checks  (checks)
  );

  // Setup, access, then hold until pready with a cycle limit
  task automatic bus_transfer(input logic write, input logic [7:0] addr,
                              input logic [31:0] data);
    int   cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    while (!done && cycles < 8) begin
      @(posedge clk);
      done = pready;
      cycles++;
    end
    if (!done) begin
      bus_errors++;
      $display("Transfer to address 0x%02h got no pready within 8 cycles", addr);
    end
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    bus_transfer(1'b1, addr, data);
  endtask

  task automatic read_reg(input logic [7:0] addr);
    bus_transfer(1'b0, addr, 32'h0);
  endtask

  initial begin
    seed    = 32'h74de_8473;
    rst     = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // Memory is zero after reset
    read_reg(8'h00);

    // Clean pass over all words
    for (int i = 0; i < `ECC_DEPTH; i++) write_reg(8'(i * 4), $random(seed));
    for (int i = 0; i < `ECC_DEPTH; i++) read_reg(8'(i * 4));
    read_reg(8'h84);

    // Single-bit fault at every codeword position
    for (int pos = 0; pos < CW; pos++) begin
      write_reg(8'h80, 32'h1 << pos);
      write_reg(8'((pos % 16) * 4), $random(seed));
      read_reg(8'((pos % 16) * 4));
      read_reg(8'h88);
      read_reg(8'h84);
    end

    // Mask is spent by one store
    write_reg(8'h80, 32'h8);
    write_reg(8'h08, $random(seed));
    read_reg(8'h80);
    write_reg(8'h14, $random(seed));
    read_reg(8'h14);
    read_reg(8'h84);

    // Count clear, then a clean read
    write_reg(8'h84, 32'hffff_ffff);
    read_reg(8'h84);
    read_reg(8'h14);
    read_reg(8'h84);
    read_reg(8'h88);

    // Unmapped addresses error out and change nothing
    read_reg(8'h8c);
    write_reg(8'h8c, $random(seed));
    read_reg(8'hfc);
    write_reg(8'hfc, $random(seed));
    read_reg(8'h80);
    read_reg(8'h84);
    read_reg(8'h88);

    // Two flipped bits get miscorrected
    write_reg(8'h80, 32'h0000_0003);
    write_reg(8'h20, $random(seed));
    read_reg(8'h20);
    read_reg(8'h84);
    read_reg(8'h88);

    repeat (4) @(negedge clk);
    $display("Checks: %0d, mismatches: %0d, bus errors: %0d", checks, errors, bus_errors);
    if (errors == 0 && bus_errors == 0 && checks > 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog sized from the operation count
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, test sequence did not finish", WATCHDOG_NS);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/ecc_mem_checker.sv
////////////////////////////////////////
// Testbench checker, models the ECC
// memory and compares APB read data
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ecc_settings.svh"

module ecc_mem_checker (
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire logic [`ECC_ADDR_WIDTH-1:0] paddr,
  input  wire logic                       psel,
  input  wire logic                       penable,
  input  wire logic                       pwrite,
  input  wire logic [31:0]                pwdata,
  input  wire logic [31:0]                prdata,
  input  wire logic                       pready,
  input  wire logic                       pslverr,
  output int                              errors,
  output int                              checks
);

  import ecc_pkg::*;

  localparam int DW = `ECC_DATA_WIDTH;
  localparam int CW = `ECC_CODE_WIDTH;
  localparam int PW = CW - DW;

  // Model state
  logic [CW-1:0] model_mem [`ECC_DEPTH];
  logic [CW-1:0] model_inject;
  logic [15:0]   model_cnt;
  logic [PW-1:0] model_syn;
  logic [PW-1:0] syn;
  logic [31:0]   expected;
  ecc_reg_e      sel;
  // Access cycles already spent on the current transfer
  int            wait_cycles;
  logic          ready_exp;

  // Data in ascending non-power-of-two slots, then even parity per group
  function automatic logic [CW-1:0] hamming_ref_encode(input logic [DW-1:0] data);
    logic [CW-1:0] code;
    int            d;
    logic          par;
    code = '0;
    d    = 0;
    for (int pos = 1; pos <= CW; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        code[pos-1] = data[d];
        d++;
      end
    end
    for (int p = 0; p < PW; p++) begin
      par = 1'b0;
      for (int pos = 1; pos <= CW; pos++) begin
        if (((pos >> p) & 1) != 0) par = par ^ code[pos-1];
      end
      code[(1 << p) - 1] = par;
    end
    return code;
  endfunction

  // Parity recheck over each group, parity bit included
  function automatic logic [PW-1:0] ref_syndrome(input logic [CW-1:0] code);
    logic [PW-1:0] s;
    s = '0;
    for (int p = 0; p < PW; p++) begin
      for (int pos = 1; pos <= CW; pos++) begin
        if (((pos >> p) & 1) != 0) s[p] = s[p] ^ code[pos-1];
      end
    end
    return s;
  endfunction

  // Flip the named position, then pull the data back out
  function automatic logic [DW-1:0] ref_decode(input logic [CW-1:0] code);
    logic [PW-1:0] s;
    logic [DW-1:0] data;
    int            d;
    s    = ref_syndrome(code);
    data = '0;
    d    = 0;
    if (s != '0 && int'(s) <= CW) code[s-1] = ~code[s-1];
    for (int pos = 1; pos <= CW; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        data[d] = code[pos-1];
        d++;
      end
    end
    return data;
  endfunction

  function automatic ecc_reg_e decode_addr(input logic [`ECC_ADDR_WIDTH-1:0] addr);
    if (addr < 8'h80) return REG_MEM;
    case (addr)
      8'h80:   return REG_INJECT;
      8'h84:   return REG_ERR_CNT;
      8'h88:   return REG_SYNDROME;
      default: return REG_UNMAPPED;
    endcase
  endfunction

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s at paddr 0x%02h is 0x%08h, expected 0x%08h",
               $time, what, paddr, got, exp);
    end
  endtask

  // Handshake timing, zero wait states except one for a memory read
  always @(posedge clk) begin
    if (rst) begin
      wait_cycles = 0;
    end else begin
      ready_exp = psel && penable &&
                  (pwrite || (decode_addr(paddr) != REG_MEM) || (wait_cycles > 0));
      compare_value("pready", {31'b0, pready}, {31'b0, ready_exp});
      wait_cycles = (psel && penable && !pready) ? wait_cycles + 1 : 0;
    end
  end

  // Completing cycle of each transfer
  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `ECC_DEPTH; i++) model_mem[i] = '0;
      model_inject = '0;
      model_cnt    = '0;
      model_syn    = '0;
    end else if (psel && penable && pready) begin
      sel = decode_addr(paddr);
      compare_value("pslverr", {31'b0, pslverr}, {31'b0, sel == REG_UNMAPPED});
      if (pwrite) begin
        case (sel)
          // Mask is spent by this store
          REG_MEM: begin
            model_mem[paddr[5:2]] = hamming_ref_encode(pwdata[DW-1:0]) ^ model_inject;
            model_inject          = '0;
          end
          REG_INJECT:  model_inject = pwdata[CW-1:0];
          REG_ERR_CNT: model_cnt    = '0;
          default:     ;
        endcase
      end else begin
        expected = '0;
        case (sel)
          REG_MEM: begin
            syn                = ref_syndrome(model_mem[paddr[5:2]]);
            expected[DW-1:0]   = ref_decode(model_mem[paddr[5:2]]);
            // Corrected read bumps the count and records the syndrome
            if (syn != '0 && int'(syn) <= CW) begin
              if (model_cnt != 16'hffff) model_cnt = model_cnt + 16'd1;
              model_syn = syn;
            end
          end
          REG_INJECT:   expected[CW-1:0] = model_inject;
          REG_ERR_CNT:  expected[15:0]   = model_cnt;
          REG_SYNDROME: expected[PW-1:0] = model_syn;
          default:      expected         = '0;
        endcase
        compare_value("prdata", prdata, expected);
      end
    end
  end

endmodule

`default_nettype wire

// File: design/ecc_mem_top.sv
////////////////////////////////////////
// ECC memory top level, APB slave in
// front of encoder, store and decoder
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ecc_settings.svh"

module ecc_mem_top (
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire logic [`ECC_ADDR_WIDTH-1:0] paddr,
  input  wire logic                       psel,
  input  wire logic                       penable,
  input  wire logic                       pwrite,
  input  wire logic [31:0]                pwdata,
  output logic      [31:0]                prdata,
  output logic                            pready,
  output logic                            pslverr
);

  import ecc_pkg::*;

  mem_req_t                   mem_req;
  logic [`ECC_CODE_WIDTH-1:0] wr_code;
  logic [`ECC_CODE_WIDTH-1:0] rd_code;
  dec_result_t                dec;

  // Bus side
  apb_regs u_apb_regs (
    .clk     (clk),
    .rst     (rst),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .mem_req (mem_req),
    .dec     (dec)
  );

  // Parity bits alone are not needed here
  hamming_encoder #(.DATA_WIDTH(`ECC_DATA_WIDTH)) u_encoder (
    .data  (mem_req.data),
    .code  (),
    .block (wr_code)
  );

  ecc_memory u_memory (
    .clk     (clk),
    .rst     (rst),
    .mem_req (mem_req),
    .wr_code (wr_code),
    .rd_code (rd_code)
  );

  // Decodes the registered read word
  hamming_decoder #(.DATA_WIDTH(`ECC_DATA_WIDTH)) u_decoder (
    .block  (rd_code),
    .result (dec)
  );

endmodule

`default_nettype wire

// File: design/ecc_memory.sv
////////////////////////////////////////
// 16-word codeword store, fault mask
// applied on write, registered read
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ecc_settings.svh"

module ecc_memory (
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire ecc_pkg::mem_req_t          mem_req,
  input  wire logic [`ECC_CODE_WIDTH-1:0] wr_code,
  output logic      [`ECC_CODE_WIDTH-1:0] rd_code
);

  import ecc_pkg::*;

  logic [`ECC_CODE_WIDTH-1:0] mem [`ECC_DEPTH];

  always_ff @(posedge clk) begin
    if (rst) begin
      // All-zero is a valid codeword for zero data
      for (int i = 0; i < `ECC_DEPTH; i++) begin
        mem[i] <= '0;
      end
      rd_code <= '0;
    end else begin
      // Injected faults land in the stored word
      if (mem_req.wr_en) begin
        mem[mem_req.index] <= wr_code ^ mem_req.fault_mask;
      end
      // Read word appears one cycle after the request
      // and holds until the next read
      if (mem_req.rd_en) begin
        rd_code <= mem[mem_req.index];
      end
    end
  end

  // Requests stay inside the array, index fully known
  a_index_in_depth: assert property (@(posedge clk) disable iff (rst)
    (mem_req.wr_en || mem_req.rd_en) |->
      (!$isunknown(mem_req.index) && (int'(mem_req.index) < `ECC_DEPTH)));

endmodule

`default_nettype wire

// File: design/apb_regs.sv
////////////////////////////////////////
// APB slave for the ECC memory, with
// fault mask and error status registers
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ecc_settings.svh"

module apb_regs (
  input  wire logic                       clk,
  input  wire logic                       rst,
  input  wire logic [`ECC_ADDR_WIDTH-1:0] paddr,
  input  wire logic                       psel,
  input  wire logic                       penable,
  input  wire logic                       pwrite,
  input  wire logic [31:0]                pwdata,
  output logic      [31:0]                prdata,
  output logic                            pready,
  output logic                            pslverr,
  output ecc_pkg::mem_req_t               mem_req,
  input  wire ecc_pkg::dec_result_t       dec
);

  import ecc_pkg::*;

  localparam int INDEX_WIDTH = $clog2(`ECC_DEPTH);
  localparam int SYN_WIDTH   = `GET_HAMMING_PARITY_WIDTH(`ECC_DATA_WIDTH);

  apb_state_e                 state;
  apb_state_e                 state_next;
  ecc_reg_e                   reg_sel;
  logic                       access;
  logic                       mem_rd;
  logic                       wr_en;
  logic                       rd_en;
  logic [`ECC_CODE_WIDTH-1:0] inject_q;
  logic [15:0]                err_cnt_q;
  logic [SYN_WIDTH-1:0]       syndrome_q;

  // Address decode, memory window is everything below 0x80
  always_comb begin
    if (paddr < `ECC_ADDR_WIDTH'('h80)) begin
      reg_sel = REG_MEM;
    end else begin
      case (paddr)
        `ECC_ADDR_WIDTH'('h80): reg_sel = REG_INJECT;
        `ECC_ADDR_WIDTH'('h84): reg_sel = REG_ERR_CNT;
        `ECC_ADDR_WIDTH'('h88): reg_sel = REG_SYNDROME;
        default:                reg_sel = REG_UNMAPPED;
      endcase
    end
  end

  assign access = psel && penable;
  assign mem_rd = (reg_sel == REG_MEM) && !pwrite;

  // FSM, only memory reads take the wait state
  always_comb begin
    state_next = state;
    pready     = 1'b0;
    rd_en      = 1'b0;
    case (state)
      APB_IDLE: begin
        // Setup phase seen
        if (psel && !penable) begin
          state_next = APB_ACCESS;
        end
      end
      APB_ACCESS: begin
        if (!access) begin
          state_next = APB_IDLE;
        end else if (mem_rd) begin
          // Launch the read, data arrives next cycle
          rd_en      = 1'b1;
          state_next = APB_RD_WAIT;
        end else begin
          pready     = 1'b1;
          state_next = APB_IDLE;
        end
      end
      APB_RD_WAIT: begin
        pready     = access;
        state_next = APB_IDLE;
      end
      default: state_next = APB_IDLE;
    endcase
  end

  // Memory writes go out in the first access cycle
  assign wr_en = pready && pwrite && (reg_sel == REG_MEM);

  always_comb begin
    mem_req.wr_en      = wr_en;
    mem_req.rd_en      = rd_en;
    mem_req.index      = paddr[2 +: INDEX_WIDTH];
    mem_req.data       = pwdata[`ECC_DATA_WIDTH-1:0];
    mem_req.fault_mask = inject_q;
  end

  // Read data only in the completing cycle
  always_comb begin
    prdata = '0;
    if (pready && !pwrite) begin
      case (reg_sel)
        REG_MEM:      prdata[`ECC_DATA_WIDTH-1:0] = dec.data;
        REG_INJECT:   prdata[`ECC_CODE_WIDTH-1:0] = inject_q;
        REG_ERR_CNT:  prdata[15:0]                = err_cnt_q;
        REG_SYNDROME: prdata[SYN_WIDTH-1:0]       = syndrome_q;
        default:      prdata                      = '0;
      endcase
    end
  end

  assign pslverr = pready && (reg_sel == REG_UNMAPPED);

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= APB_IDLE;
      inject_q   <= '0;
      err_cnt_q  <= '0;
      syndrome_q <= '0;
    end else begin
      state <= state_next;
      if (pready && pwrite) begin
        case (reg_sel)
          // Mask is one-shot, spent by this store
          REG_MEM:     inject_q  <= '0;
          REG_INJECT:  inject_q  <= pwdata[`ECC_CODE_WIDTH-1:0];
          REG_ERR_CNT: err_cnt_q <= '0;
          default:     ;
        endcase
      end
      // Corrected read completing
      if (pready && mem_rd && dec.corrected) begin
        if (err_cnt_q != '1) begin
          err_cnt_q <= err_cnt_q + 1'b1;
        end
        syndrome_q <= dec.syndrome;
      end
    end
  end

  // Completion only inside an APB access phase
  a_pready_in_access: assert property (@(posedge clk) disable iff (rst)
    pready |-> (psel && penable));

  // Store and fetch never share a cycle
  a_wr_rd_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(mem_req.wr_en && mem_req.rd_en));

endmodule

`default_nettype wire

// File: hamming/hamming_decoder.sv
////////////////////////////////////////
// Combinational Hamming decoder with
// single-bit correction, no DED
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ecc_settings.svh"

module hamming_decoder #(
  parameter  int DATA_WIDTH   = `ECC_DATA_WIDTH,
  localparam int PARITY_WIDTH = `GET_HAMMING_PARITY_WIDTH(DATA_WIDTH),
  localparam int BLOCK_WIDTH  = DATA_WIDTH + PARITY_WIDTH
) (
  input  wire logic [BLOCK_WIDTH-1:0] block,
  output ecc_pkg::dec_result_t        result
);

  import ecc_pkg::*;

  logic [PARITY_WIDTH-1:0] syndrome;
  logic                    in_range;
  logic [BLOCK_WIDTH-1:0]  flip;
  logic [BLOCK_WIDTH-1:0]  fixed;
  logic [DATA_WIDTH-1:0]   data;

  // Recheck every parity group, parity bit included
  // A clean word gives all zeros
  for (genvar p = 0; p < PARITY_WIDTH; p++) begin : g_syndrome
    localparam logic [63:0] COVER = hamming_cover(p);
    assign syndrome[p] = ^(block & COVER[BLOCK_WIDTH-1:0]);
  end

  // Syndrome is the 1-based position of the bad bit
  // Values past the codeword come from multi-bit errors
  assign in_range = (syndrome != '0) && (int'(syndrome) <= BLOCK_WIDTH);

  // One-hot flip of the position named by the syndrome
  always_comb begin
    flip = '0;
    if (in_range) begin
      flip[syndrome - 1'b1] = 1'b1;
    end
  end

  assign fixed = block ^ flip;

  // Pull data back out of the non-power-of-two slots
  for (genvar pos = 1; pos <= BLOCK_WIDTH; pos++) begin : g_extract
    if ((pos & (pos - 1)) != 0) begin : g_data
      assign data[pos - $clog2(pos + 1) - 1] = fixed[pos-1];
    end
  end

  // Pack the result for the APB side
  always_comb begin
    result.data      = data;
    result.syndrome  = syndrome;
    result.corrected = in_range;
  end

endmodule

`default_nettype wire

// File: hamming/hamming_encoder.sv
////////////////////////////////////////
// Combinational Hamming encoder, places
// parity at power-of-two positions
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "ecc_settings.svh"

module hamming_encoder #(
  parameter  int DATA_WIDTH   = `ECC_DATA_WIDTH,
  localparam int PARITY_WIDTH = `GET_HAMMING_PARITY_WIDTH(DATA_WIDTH),
  localparam int BLOCK_WIDTH  = DATA_WIDTH + PARITY_WIDTH
) (
  input  wire logic [DATA_WIDTH-1:0]   data,
  output logic      [PARITY_WIDTH-1:0] code,
  output logic      [BLOCK_WIDTH-1:0]  block
);

  import ecc_pkg::*;

  // Full Hamming size for this parity count
  localparam int PAD_DATA_WIDTH  = `GET_HAMMING_DATA_WIDTH(PARITY_WIDTH);
  localparam int PAD_BLOCK_WIDTH = PAD_DATA_WIDTH + PARITY_WIDTH;

  logic [PAD_DATA_WIDTH-1:0]  data_pad;
  logic [PAD_BLOCK_WIDTH-1:0] spread;
  logic [PAD_BLOCK_WIDTH-1:0] block_pad;
  logic [PARITY_WIDTH-1:0]    parity;

  // Upper data bits are zero padding
  assign data_pad = {{(PAD_DATA_WIDTH - DATA_WIDTH){1'b0}}, data};

  // Walk the 1-based positions
  // Data fills non-power-of-two slots in ascending order
  for (genvar pos = 1; pos <= PAD_BLOCK_WIDTH; pos++) begin : g_place
    if ((pos & (pos - 1)) == 0) begin : g_parity
      // Parity slot, left empty in the data-only view
      assign spread[pos-1]    = 1'b0;
      assign block_pad[pos-1] = parity[$clog2(pos)];
    end else begin : g_data
      // Data index is the position minus the parity slots below it
      assign spread[pos-1]    = data_pad[pos - $clog2(pos + 1) - 1];
      assign block_pad[pos-1] = spread[pos-1];
    end
  end

  // Each parity bit covers the positions with its index bit set
  for (genvar p = 0; p < PARITY_WIDTH; p++) begin : g_parity_calc
    localparam logic [63:0] COVER = hamming_cover(p);
    assign parity[p] = ^(spread & COVER[PAD_BLOCK_WIDTH-1:0]);
  end

  assign code = parity;

  // Padding only lands above the real codeword
  assign block = block_pad[BLOCK_WIDTH-1:0];

endmodule

`default_nettype wire

// File: common/ecc_pkg.sv
////////////////////////////////////////
// Types shared by the ECC memory RTL
// and its testbench
////////////////////////////////////////

`default_nettype none

`include "ecc_settings.svh"

package ecc_pkg;

  // APB slave states
  typedef enum logic [1:0] {
    APB_IDLE    = 2'd0,
    APB_ACCESS  = 2'd1,
    APB_RD_WAIT = 2'd2
  } apb_state_e;

  // Register select from address decode
  typedef enum logic [2:0] {
    REG_MEM      = 3'd0,
    REG_INJECT   = 3'd1,
    REG_ERR_CNT  = 3'd2,
    REG_SYNDROME = 3'd3,
    REG_UNMAPPED = 3'd4
  } ecc_reg_e;

  // Request from the APB side to the codeword store
  typedef struct packed {
    logic                            wr_en;
    logic                            rd_en;
    logic [$clog2(`ECC_DEPTH)-1:0]   index;
    logic [`ECC_DATA_WIDTH-1:0]      data;
    logic [`ECC_CODE_WIDTH-1:0]      fault_mask;
  } mem_req_t;

  // Decoder output back to the APB side
  typedef struct packed {
    logic [`ECC_DATA_WIDTH-1:0]                            data;
    logic [`GET_HAMMING_PARITY_WIDTH(`ECC_DATA_WIDTH)-1:0] syndrome;
    logic                                                  corrected;
  } dec_result_t;

  // Coverage mask of one parity check
  // Bit i is set when 1-based position i+1 has bit parity_index set
  function automatic logic [63:0] hamming_cover(input int parity_index);
    logic [63:0] mask;
    mask = '0;
    for (int pos = 1; pos <= 64; pos++) begin
      mask[pos-1] = ((pos >> parity_index) & 1) != 0;
    end
    return mask;
  endfunction

endpackage

`default_nettype wire

// File: common/ecc_settings.svh
////////////////////////////////////////
// Width and depth settings for the ECC
// memory, plus the Hamming size formulas
////////////////////////////////////////

`ifndef ECC_SETTINGS_SVH
`define ECC_SETTINGS_SVH

// Data word carried over APB and stored in memory
`define ECC_DATA_WIDTH 16

// Smallest parity count p whose covered data size 2^p-p-1 holds dw bits
`define GET_HAMMING_PARITY_WIDTH(dw) \
  (((dw) <= 1)   ? 2 : \
   ((dw) <= 4)   ? 3 : \
   ((dw) <= 11)  ? 4 : \
   ((dw) <= 26)  ? 5 : \
   ((dw) <= 57)  ? 6 : \
   ((dw) <= 120) ? 7 : 8)

// Padded data size covered by pw parity bits
`define GET_HAMMING_DATA_WIDTH(pw) ((2 ** (pw)) - (pw) - 1)

// Stored codeword, data plus parity
`define ECC_CODE_WIDTH (`ECC_DATA_WIDTH + `GET_HAMMING_PARITY_WIDTH(`ECC_DATA_WIDTH))

// Number of memory words
`define ECC_DEPTH 16

// APB address bus
`define ECC_ADDR_WIDTH 8

`endif
